// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ieu_tb
FLIST     = flist.f
BUILD     = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the ieu testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== flist.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/cdb_pkg.sv
rtl/ieu_stage_reg.sv
rtl/ieu_id.sv
rtl/ieu_ex.sv
rtl/ieu.sv
verification/ieu_asserts.sv
verification/ieu_checker.sv
verification/ieu_tb.sv

// ==== rtl/cdb_pkg.sv ====
// --------------------
// result format broadcast on the common data bus
// --------------------

`include "ieu_defines.svh"

package cdb_pkg;

    typedef struct packed {
        logic [`IEU_DATA_WIDTH-1:0] data;
        logic [`IEU_ADDR_WIDTH-1:0] addr;     // next instruction address
        logic [`IEU_TAG_WIDTH-1:0]  tag;
        logic                       redirect; // taken branch or jump
    } cdb_result_t;

endpackage

// ==== rtl/ieu.sv ====
// --------------------
// integer execution unit, ID and EX stages with the result on the CDB
// issue to CDB takes two cycles and i_flush drops both stages
// --------------------

`timescale 1ns/1ns
`include "ieu_defines.svh"

module ieu (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       i_flush,

    // issue from the reservation station
    input  logic                       i_valid,
    input  logic [31:0]                i_insn,
    input  logic [`IEU_ADDR_WIDTH-1:0] i_iaddr,
    input  logic [`IEU_DATA_WIDTH-1:0] i_src_a,
    input  logic [`IEU_DATA_WIDTH-1:0] i_src_b,
    input  logic [`IEU_TAG_WIDTH-1:0]  i_tag,

    // CDB
    output logic                       o_cdb_en,
    output logic                       o_cdb_redirect,
    output logic [`IEU_TAG_WIDTH-1:0]  o_cdb_tag,
    output logic [`IEU_ADDR_WIDTH-1:0] o_cdb_addr,
    output logic [`IEU_DATA_WIDTH-1:0] o_cdb_data
);

    import isa_pkg::*;
    import cdb_pkg::*;

    ieu_op_t     id_op;
    logic        id_valid;
    ieu_op_t     id_op_q;
    logic        id_valid_q;
    cdb_result_t ex_res;
    logic        ex_valid;
    cdb_result_t ex_res_q;

    ieu_id ieu_id_inst (
        .i_insn  (i_insn),
        .i_iaddr (i_iaddr),
        .i_src_a (i_src_a),
        .i_src_b (i_src_b),
        .i_tag   (i_tag),
        .i_valid (i_valid),
        .o_op    (id_op),
        .o_valid (id_valid)
    );

    ieu_stage_reg #(.payload_t(ieu_op_t)) id_ex_reg (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_flush (i_flush),
        .i_valid (id_valid),
        .i_data  (id_op),
        .o_valid (id_valid_q),
        .o_data  (id_op_q)
    );

    ieu_ex ieu_ex_inst (
        .i_op     (id_op_q),
        .i_valid  (id_valid_q && !i_flush), // a flushed op leaves no redirect behind
        .o_result (ex_res),
        .o_valid  (ex_valid)
    );

    ieu_stage_reg #(.payload_t(cdb_result_t)) ex_cdb_reg (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_flush (i_flush),
        .i_valid (ex_valid),
        .i_data  (ex_res),
        .o_valid (o_cdb_en),
        .o_data  (ex_res_q)
    );

    assign o_cdb_redirect = ex_res_q.redirect;
    assign o_cdb_tag      = ex_res_q.tag;
    assign o_cdb_addr     = ex_res_q.addr;
    assign o_cdb_data     = ex_res_q.data;

endmodule

// ==== rtl/ieu_defines.svh ====
// --------------------
// width macros for the integer execution unit
// included by the packages, the RTL and the testbench
// --------------------

`ifndef IEU_DEFINES_SVH
`define IEU_DEFINES_SVH

// datapath
`define IEU_DATA_WIDTH 32
`define IEU_ADDR_WIDTH 32

// result tag handed out by the reservation station
`define IEU_TAG_WIDTH 6

`endif

// ==== rtl/ieu_ex.sv ====
// --------------------
// EX stage: ALU, branch compare and next address
// purely combinational and registered by the CDB stage register
// --------------------

`timescale 1ns/1ns
`include "ieu_defines.svh"

module ieu_ex (
    input  isa_pkg::ieu_op_t     i_op,
    input  logic                 i_valid,
    output cdb_pkg::cdb_result_t o_result,
    output logic                 o_valid
);

    import isa_pkg::*;

    logic [`IEU_DATA_WIDTH-1:0] op_a;
    logic [`IEU_DATA_WIDTH-1:0] op_b;
    logic [`IEU_DATA_WIDTH-1:0] alu_res;
    logic                       eq;
    logic                       lt;
    logic                       ltu;
    logic                       taken;
    logic                       jalr;
    logic                       redirect;
    logic [`IEU_ADDR_WIDTH-1:0] link;
    logic [`IEU_ADDR_WIDTH-1:0] rel_target;
    logic [`IEU_ADDR_WIDTH-1:0] target;

    assign op_a = i_op.src_a;
    assign op_b = i_op.src_b;

    // --------------------
    // ALU
    // --------------------
    assign eq  = (op_a == op_b);
    assign lt  = ($signed(op_a) < $signed(op_b));
    assign ltu = (op_a < op_b);

    always_comb begin
        case (i_op.alu_func)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            SLL:     alu_res = op_a << i_op.shamt;
            SLT:     alu_res = {{(`IEU_DATA_WIDTH-1){1'b0}}, lt};
            SLTU:    alu_res = {{(`IEU_DATA_WIDTH-1){1'b0}}, ltu};
            XOR:     alu_res = op_a ^ op_b;
            SRL:     alu_res = op_a >> i_op.shamt;
            SRA:     alu_res = $signed(op_a) >>> i_op.shamt;
            OR:      alu_res = op_a | op_b;
            AND:     alu_res = op_a & op_b;
            PASS_B:  alu_res = op_b;
            default: alu_res = '0;     // branch codes
        endcase
    end

    // branch condition where SLTU doubles as bltu
    always_comb begin
        case (i_op.alu_func)
            BEQ:     taken = eq;
            BNE:     taken = !eq;
            BLT:     taken = lt;
            BGE:     taken = !lt;
            SLTU:    taken = ltu;
            BGEU:    taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // --------------------
    // next address
    // --------------------
    assign jalr       = i_op.jmp && (i_op.alu_func != PASS_B);
    assign link       = i_op.iaddr + `IEU_ADDR_WIDTH'd4;
    assign rel_target = i_op.iaddr + i_op.imm;   // jal and branches
    assign target     = jalr ? {alu_res[`IEU_ADDR_WIDTH-1:1], 1'b0} : rel_target;
    assign redirect   = i_valid && (i_op.jmp || (i_op.br && taken)); // only for a live op

    always_comb begin
        if (i_op.jmp) begin
            o_result.data = link;
        end else if (i_op.br) begin
            o_result.data = '0;
        end else begin
            o_result.data = alu_res;
        end
        o_result.addr     = redirect ? target : link;
        o_result.tag      = i_op.tag;
        o_result.redirect = redirect;
    end

    assign o_valid = i_valid;

endmodule

// ==== rtl/ieu_id.sv ====
// --------------------
// ID stage: decodes an issued RV32I integer instruction into an op for EX
// purely combinational, registered by the first stage register
// --------------------

`timescale 1ns/1ns
`include "ieu_defines.svh"

module ieu_id (
    input  logic [31:0]                i_insn,
    input  logic [`IEU_ADDR_WIDTH-1:0] i_iaddr,
    input  logic [`IEU_DATA_WIDTH-1:0] i_src_a,
    input  logic [`IEU_DATA_WIDTH-1:0] i_src_b,
    input  logic [`IEU_TAG_WIDTH-1:0]  i_tag,
    input  logic                       i_valid,
    output isa_pkg::ieu_op_t           o_op,
    output logic                       o_valid
);

    import isa_pkg::*;

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic                       funct7_b5;
    logic [`IEU_DATA_WIDTH-1:0] imm_i;
    logic [`IEU_DATA_WIDTH-1:0] imm_u;
    logic [`IEU_DATA_WIDTH-1:0] imm_j;
    logic [`IEU_DATA_WIDTH-1:0] imm_b;
    alu_func_t                  arith_func;
    alu_func_t                  branch_func;
    logic [`IEU_DATA_WIDTH-1:0] op_b;

    assign opcode    = i_insn[6:0];
    assign funct3    = i_insn[14:12];
    assign funct7_b5 = i_insn[30]; // sub / sra select

    // --------------------
    // immediates
    // --------------------
    assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
    assign imm_u = {i_insn[31:12], 12'b0};
    assign imm_j = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
    assign imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};

    // funct3 map shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000:  arith_func = (opcode == OP && funct7_b5) ? SUB : ADD; // no subi
            3'b001:  arith_func = SLL;
            3'b010:  arith_func = SLT;
            3'b011:  arith_func = SLTU;
            3'b100:  arith_func = XOR;
            3'b101:  arith_func = funct7_b5 ? SRA : SRL;
            3'b110:  arith_func = OR;
            default: arith_func = AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  branch_func = BEQ;
            3'b001:  branch_func = BNE;
            3'b100:  branch_func = BLT;
            3'b101:  branch_func = BGE;
            3'b110:  branch_func = SLTU; // bltu
            3'b111:  branch_func = BGEU;
            default: branch_func = BEQ;
        endcase
    end

    // --------------------
    // op assembly
    // --------------------
    always_comb begin
        o_op.alu_func = ADD;
        o_op.src_a    = i_src_a;
        o_op.imm      = imm_i;
        o_op.jmp      = 1'b0;
        o_op.br       = 1'b0;
        op_b          = i_src_b;
        o_valid       = i_valid;

        case (opcode)
            OP: begin
                o_op.alu_func = arith_func;
            end
            OP_IMM: begin
                o_op.alu_func = arith_func;
                op_b          = imm_i;
            end
            LUI: begin
                o_op.alu_func = PASS_B;
                o_op.imm      = imm_u;
                op_b          = imm_u;
            end
            AUIPC: begin
                o_op.src_a = i_iaddr;  // iaddr + imm through the adder
                o_op.imm   = imm_u;
                op_b       = imm_u;
            end
            JAL: begin
                o_op.alu_func = PASS_B; // tells EX this is not jalr
                o_op.imm      = imm_j;
                o_op.jmp      = 1'b1;
                op_b          = imm_j;
            end
            JALR: begin
                o_op.jmp = 1'b1;       // ADD forms rs1 + imm
                op_b     = imm_i;
            end
            BRANCH: begin
                o_op.alu_func = branch_func;
                o_op.imm      = imm_b;
                o_op.br       = 1'b1;
            end
            default: begin
                o_valid = 1'b0;        // not an integer op
            end
        endcase

        o_op.src_b = op_b;
        o_op.shamt = op_b[4:0];        // rs2[4:0] or insn[24:20]
        o_op.iaddr = i_iaddr;
        o_op.tag   = i_tag;
    end

endmodule

// ==== rtl/ieu_stage_reg.sv ====
// --------------------
// one pipeline stage: payload of any type plus a flushable valid
// --------------------

`timescale 1ns/1ns

module ieu_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     n_rst,
    input  logic     i_flush,
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_valid,
    output payload_t o_data
);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0; // drop whatever is in flight
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_data <= i_data;
    end

endmodule

// ==== rtl/isa_pkg.sv ====
// --------------------
// RV32I opcodes, ALU functions and the decoded op passed from ID to EX
// --------------------

`include "ieu_defines.svh"

package isa_pkg;

    // major opcodes, insn[6:0]
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] BRANCH = 7'b1100011;

    // BLTU shares the SLTU code, br tells the two apart
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B,                 // lui, also marks jal
        BEQ, BNE, BLT, BGE, BGEU
    } alu_func_t;

    typedef struct packed {
        alu_func_t                  alu_func;
        logic [`IEU_DATA_WIDTH-1:0] src_a;
        logic [`IEU_DATA_WIDTH-1:0] src_b;  // register or immediate
        logic [`IEU_ADDR_WIDTH-1:0] iaddr;
        logic [`IEU_DATA_WIDTH-1:0] imm;    // for jump and branch targets
        logic [4:0]                 shamt;
        logic [`IEU_TAG_WIDTH-1:0]  tag;
        logic                       jmp;
        logic                       br;
    } ieu_op_t;

endpackage

// ==== verification/ieu_asserts.sv ====
// --------------------
// protocol assertions on the ieu ports, bound into every ieu instance
// --------------------

`timescale 1ns/1ns

module ieu_asserts (
    input logic        clk,
    input logic        n_rst,
    input logic        i_flush,
    input logic        i_valid,
    input logic [31:0] i_insn,
    input logic        i_cdb_en,
    input logic        i_cdb_redirect
);

    import isa_pkg::*;

    logic legal;
    int   fail_count = 0;

    assign legal = i_insn[6:0] inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH};

    reset_idle: assert property (@(posedge clk) !n_rst |-> !i_cdb_en)
        else begin
            $error("CDB enable active while in reset");
            fail_count++;
        end

    // a flush at the edge after issue kills it, one at the result edge does not
    issue_latency: assert property (@(posedge clk) disable iff (!n_rst)
        ($past(i_valid && legal && !i_flush, 2) && !$past(i_flush)) |-> i_cdb_en)
        else begin
            $error("issued instruction did not reach the CDB two cycles later");
            fail_count++;
        end

    redirect_needs_en: assert property (@(posedge clk) disable iff (!n_rst)
        i_cdb_redirect |-> i_cdb_en)
        else begin
            $error("CDB redirect without CDB enable");
            fail_count++;
        end

endmodule

bind ieu ieu_asserts ieu_asserts_i (
    .clk            (clk),
    .n_rst          (n_rst),
    .i_flush        (i_flush),
    .i_valid        (i_valid),
    .i_insn         (i_insn),
    .i_cdb_en       (o_cdb_en),
    .i_cdb_redirect (o_cdb_redirect)
);

// ==== verification/ieu_checker.sv ====
// --------------------
// scoreboard for ieu: predicts CDB results from the issue ports
// and compares them with the CDB in order, counting errors
// --------------------

`timescale 1ns/1ns
`include "ieu_defines.svh"

module ieu_checker (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       i_flush,
    input  logic                       i_valid,
    input  logic [31:0]                i_insn,
    input  logic [`IEU_ADDR_WIDTH-1:0] i_iaddr,
    input  logic [`IEU_DATA_WIDTH-1:0] i_src_a,
    input  logic [`IEU_DATA_WIDTH-1:0] i_src_b,
    input  logic [`IEU_TAG_WIDTH-1:0]  i_tag,
    input  logic                       i_cdb_en,
    input  logic                       i_cdb_redirect,
    input  logic [`IEU_TAG_WIDTH-1:0]  i_cdb_tag,
    input  logic [`IEU_ADDR_WIDTH-1:0] i_cdb_addr,
    input  logic [`IEU_DATA_WIDTH-1:0] i_cdb_data,
    input  logic                       i_end,
    output int                         o_errors
);

    import isa_pkg::*;
    import cdb_pkg::*;

    cdb_result_t exp_q[$];
    int          cyc_q[$];
    string       name_q[$];
    cdb_result_t act;
    cdb_result_t exp;
    string       name;
    int          issued_at;
    int          cycle = 0;
    logic        end_seen = 1'b0;

    assign act = {i_cdb_data, i_cdb_addr, i_cdb_tag, i_cdb_redirect};

    initial o_errors = 0;

    function automatic logic is_legal(input logic [31:0] w);
        return w[6:0] inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH};
    endfunction

    function automatic string insn_name(input logic [31:0] w);
        case (w[6:0])
            OP:      return $sformatf("op_f3_%0d%s", w[14:12], w[30] ? "_alt" : "");
            OP_IMM:  return $sformatf("op_imm_f3_%0d", w[14:12]);
            LUI:     return "lui";
            AUIPC:   return "auipc";
            JAL:     return "jal";
            JALR:    return "jalr";
            default: return $sformatf("branch_f3_%0d", w[14:12]);
        endcase
    endfunction

    // RV32I integer arithmetic by funct3, alt picks sub or sra
    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] x, input logic [31:0] y);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? x - y : x + y;
            3'd1: r = x << y[4:0];
            3'd2: r = {31'b0, $signed(x) < $signed(y)};
            3'd3: r = {31'b0, x < y};
            3'd4: r = x ^ y;
            3'd5: begin
                if (alt) r = $signed(x) >>> y[4:0];
                else     r = x >> y[4:0];
            end
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic cdb_result_t ref_result(input logic [31:0] w, input logic [31:0] pc,
                                               input logic [31:0] a, input logic [31:0] b,
                                               input logic [`IEU_TAG_WIDTH-1:0] t);
        cdb_result_t r;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] imm_b;
        logic        taken;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_u = {w[31:12], 12'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        r.tag      = t;
        r.redirect = 1'b0;
        r.addr     = pc + 32'd4;
        r.data     = '0;
        case (w[6:0])
            OP:     r.data = alu_calc(w[14:12], w[30], a, b);
            OP_IMM: r.data = alu_calc(w[14:12], w[30] && (w[14:12] == 3'd5), a, imm_i);
            LUI:    r.data = imm_u;
            AUIPC:  r.data = pc + imm_u;
            JAL: begin
                r.data     = pc + 32'd4;
                r.redirect = 1'b1;
                r.addr     = pc + imm_j;
            end
            JALR: begin
                r.data     = pc + 32'd4;
                r.redirect = 1'b1;
                r.addr     = (a + imm_i) & ~32'd1;
            end
            default: begin
                case (w[14:12])
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                r.redirect = taken;
                if (taken) r.addr = pc + imm_b;
            end
        endcase
        return r;
    endfunction

    // --------------------
    // compare, then update
    // --------------------
    always @(posedge clk) begin
        cycle++;
        if (n_rst) begin
            if (i_cdb_en) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected CDB result with tag %0d, nothing is pending", i_cdb_tag);
                    o_errors++;
                end else begin
                    exp       = exp_q.pop_front();
                    issued_at = cyc_q.pop_front();
                    name      = name_q.pop_front();
                    if (cycle - issued_at != 2) begin
                        $display("%s with tag %0d arrived %0d cycles after issue instead of 2",
                                 name, exp.tag, cycle - issued_at);
                        o_errors++;
                    end
                    if (act != exp) begin
                        $display("ERROR %s: expected data=%h addr=%h tag=%0d redirect=%b, %s",
                                 name, exp.data, exp.addr, exp.tag, exp.redirect,
                                 $sformatf("actual data=%h addr=%h tag=%0d redirect=%b",
                                           act.data, act.addr, act.tag, act.redirect));
                        o_errors++;
                    end
                end
            end
            // anything left that was due by now never showed up
            while (cyc_q.size() > 0 && cyc_q[0] <= cycle - 2) begin
                $display("%s with tag %0d never appeared on the CDB", name_q[0], exp_q[0].tag);
                void'(exp_q.pop_front());
                void'(cyc_q.pop_front());
                void'(name_q.pop_front());
                o_errors++;
            end
            if (i_flush) begin
                while (cyc_q.size() > 0 && cyc_q[$] > cycle - 3) begin
                    void'(exp_q.pop_back());
                    void'(cyc_q.pop_back());
                    void'(name_q.pop_back());
                end
            end else if (i_valid && is_legal(i_insn)) begin
                exp_q.push_back(ref_result(i_insn, i_iaddr, i_src_a, i_src_b, i_tag));
                cyc_q.push_back(cycle);
                name_q.push_back(insn_name(i_insn));
            end
            if (i_end && !end_seen) begin
                end_seen = 1'b1;
                if (exp_q.size() > 0) begin
                    $display("%0d expected results still pending at end of run", exp_q.size());
                    o_errors += exp_q.size();
                end
            end
        end
    end

endmodule

// ==== verification/ieu_tb.sv ====
// --------------------
// testbench top for ieu with clock, reset, directed and random issue,
// flush, timeout and the final verdict
// --------------------

`timescale 1ns/1ns
`include "ieu_defines.svh"

module ieu_tb;

    import isa_pkg::*;

    localparam int RST_CYCLES   = 5;
    localparam int ISSUE_CYCLES = 142;
    localparam int IDLE_CYCLES  = 7 * 4 + 6 + 2;
    localparam int TIMEOUT      = RST_CYCLES + ISSUE_CYCLES + IDLE_CYCLES + 50;
    localparam logic [31:0] NOP = 32'h0000_0013; // addi x0, x0, 0

    logic                       clk;
    logic                       n_rst;
    logic                       flush;
    logic                       valid;
    logic [31:0]                insn;
    logic [`IEU_ADDR_WIDTH-1:0] iaddr;
    logic [`IEU_DATA_WIDTH-1:0] src_a;
    logic [`IEU_DATA_WIDTH-1:0] src_b;
    logic [`IEU_TAG_WIDTH-1:0]  tag;
    logic                       cdb_en;
    logic                       cdb_redirect;
    logic [`IEU_TAG_WIDTH-1:0]  cdb_tag;
    logic [`IEU_ADDR_WIDTH-1:0] cdb_addr;
    logic [`IEU_DATA_WIDTH-1:0] cdb_data;
    logic                       end_run;
    int                         errors;
    int                         total;
    int                         cycles = 0;
    logic [31:0]                pc = 32'h0000_1000;
    logic [`IEU_TAG_WIDTH-1:0]  next_tag = '0;

    ieu ieu_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (flush),
        .i_valid        (valid),
        .i_insn         (insn),
        .i_iaddr        (iaddr),
        .i_src_a        (src_a),
        .i_src_b        (src_b),
        .i_tag          (tag),
        .o_cdb_en       (cdb_en),
        .o_cdb_redirect (cdb_redirect),
        .o_cdb_tag      (cdb_tag),
        .o_cdb_addr     (cdb_addr),
        .o_cdb_data     (cdb_data)
    );

    ieu_checker ieu_checker_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (flush),
        .i_valid        (valid),
        .i_insn         (insn),
        .i_iaddr        (iaddr),
        .i_src_a        (src_a),
        .i_src_b        (src_b),
        .i_tag          (tag),
        .i_cdb_en       (cdb_en),
        .i_cdb_redirect (cdb_redirect),
        .i_cdb_tag      (cdb_tag),
        .i_cdb_addr     (cdb_addr),
        .i_cdb_data     (cdb_data),
        .i_end          (end_run),
        .o_errors       (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // instruction encoders
    // --------------------
    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $urandom();
        return r[4:0];
    endfunction

    function automatic logic [31:0] r_enc(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {f7, rand_reg(), rand_reg(), f3, rand_reg(), opc};
    endfunction

    function automatic logic [31:0] i_enc(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm, rand_reg(), f3, rand_reg(), opc};
    endfunction

    function automatic logic [31:0] j_enc(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rand_reg(), JAL};
    endfunction

    function automatic logic [31:0] b_enc(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], rand_reg(), rand_reg(), f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] rand_alu_insn();
        logic [31:0] r;
        logic [6:0]  f7;
        r  = $urandom();
        f7 = ((r[2:0] == 3'd0 || r[2:0] == 3'd5) && r[3]) ? 7'b0100000 : 7'b0;
        return r_enc(f7, r[2:0], OP);
    endfunction

    task automatic issue(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        valid <= 1'b1;
        insn  <= w;
        iaddr <= pc;
        src_a <= a;
        src_b <= b;
        tag   <= next_tag;
        pc       = pc + 32'd4;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid <= 1'b0;
            flush <= 1'b0;
            insn  <= NOP;
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        logic [2:0]  br_f3[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [2:0]  imm_f3[6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        void'($urandom(32'h9c2c));
        n_rst   = 1'b0;
        flush   = 1'b0;
        valid   = 1'b0;
        insn    = NOP;
        end_run = 1'b0;
        iaddr   = '0;
        src_a   = '0;
        src_b   = '0;
        tag     = '0;
        repeat (RST_CYCLES) @(posedge clk);
        n_rst <= 1'b1;

        // all ten R-type ops
        repeat (4) begin
            for (int i = 0; i < 8; i++) begin
                f3 = 3'(i);
                issue(r_enc(7'b0, f3, OP), $urandom(), $urandom());
            end
            issue(r_enc(7'b0100000, 3'd0, OP), $urandom(), $urandom());
            issue(r_enc(7'b0100000, 3'd5, OP), $urandom(), $urandom());
        end
        idle(4);
        // I-type including the three immediate shifts
        repeat (4) begin
            foreach (imm_f3[i]) begin
                r = $urandom();
                issue(i_enc(r[11:0], imm_f3[i], OP_IMM), $urandom(), $urandom());
            end
            r = $urandom();
            issue(i_enc({7'b0, r[4:0]}, 3'd1, OP_IMM), $urandom(), $urandom());
            issue(i_enc({7'b0, r[9:5]}, 3'd5, OP_IMM), $urandom(), $urandom());
            issue(i_enc({7'b0100000, r[14:10]}, 3'd5, OP_IMM), 32'h8000_0000 | $urandom(), 0);
        end
        idle(4);
        repeat (4) begin
            r = $urandom();
            issue({r[31:12], rand_reg(), LUI}, $urandom(), $urandom());
            r = $urandom();
            issue({r[31:12], rand_reg(), AUIPC}, $urandom(), $urandom());
        end
        idle(4);
        // each branch sees equal, negative vs positive and positive vs negative
        foreach (br_f3[i]) begin
            r = $urandom();
            issue(b_enc({r[12:1], 1'b0}, br_f3[i]), 32'h1234, 32'h1234);
            issue(b_enc({r[24:13], 1'b0}, br_f3[i]), 32'h8000_0010, 32'h10);
            issue(b_enc({r[30:19], 1'b0}, br_f3[i]), 32'h10, 32'h8000_0010);
        end
        idle(4);
        repeat (3) begin
            r = $urandom();
            issue(j_enc({r[20:1], 1'b0}), $urandom(), $urandom());
            r = $urandom();
            issue(i_enc(r[11:0], 3'd0, JALR), $urandom() | 32'd1, $urandom());
        end
        idle(4);
        repeat (20) issue(rand_alu_insn(), $urandom(), $urandom());
        idle(4);
        // flush mid stream while a jalr and a jal are in flight
        repeat (5) issue(rand_alu_insn(), $urandom(), $urandom());
        r = $urandom();
        issue(i_enc(r[11:0], 3'd0, JALR), $urandom(), $urandom());
        issue(j_enc({r[31:12], 1'b0}), $urandom(), $urandom());
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        valid <= 1'b0;
        repeat (5) issue(rand_alu_insn(), $urandom(), $urandom());
        idle(4);
        issue({25'h0, 7'b0000011}, $urandom(), $urandom()); // load is not handled here
        idle(6);

        end_run <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        total = errors + ieu_i.ieu_asserts_i.fail_count;
        $display("errors: %0d", total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

endmodule
